/* sim/ppu_out_input.txt */
// cfg_word pins lines pix probe lat_vd lat_sync | vd_o ncsync_o vga_f_pins vclk_sel state
// pins = {palmode, n64_480i, use_vpll, use_vga_hvsync}, one vector per line
// RGB bypass and YPbPr colours
0000 1 0 0 F4080C0 4 4 4080C0 2 3 0 01
0004 1 0 0 FFFFFFF 4 4 80FF80 3 3 0 09
0004 1 0 0 FFF0000 4 4 FF4C55 3 3 0 09
0004 1 0 0 F0000FF 4 4 6B1CFF 3 3 0 09
0004 1 0 0 F4080C0 4 4 5A74AA 3 3 0 09
// Red/blue exchange
0002 1 0 0 F4080C0 4 4 C08040 2 3 0 01
0006 1 0 0 FFF0000 4 4 554CFF 3 3 0 09
// Test pattern cells
0201 3 0 0 F123456 5 5 000000 2 3 0 01
0201 3 0 8 F123456 5 5 FFFFFF 2 3 0 01
0201 3 9 3 F123456 5 5 FFFFFF 2 3 0 01
// Line multiplier rules
0200 2 0 0 F4080C0 4 4 4080C0 2 2 2 21
0200 A 0 0 F4080C0 4 4 4080C0 2 1 1 91
0200 0 0 0 F4080C0 4 4 4080C0 2 1 1 11
0300 6 0 0 F4080C0 4 4 4080C0 2 1 1 51
// Composite sync, filter code and VGA pins
0018 0 0 0 F4080C0 4 4 4080C0 3 0 0 04
0028 0 0 0 E4080C0 4 4 4080C0 0 1 0 04
0030 0 0 0 F4080C0 4 4 4080C0 2 2 0 00
0040 0 0 0 F4080C0 4 4 4080C0 2 3 0 00
0008 1 0 0 64080C0 4 4 4080C0 0 1 0 05
// De-blur
0500 0 0 0 F4080C0 5 4 4080C0 2 1 1 13
0400 0 0 0 F4080C0 6 4 4080C0 2 0 0 03
0500 4 0 0 F4080C0 4 4 4080C0 2 1 1 51
// End marker
FFFFFFFF

/* ppu_out.f */
src/ppu_out_pkg.sv
src/ppu_cfg_regs.sv
src/ppu_testpattern.sv
src/ppu_vconv.sv
src/ppu_out_stage.sv
src/ppu_out_top.sv
sim/tb_ppu_out_top.sv

/* sim/tb_ppu_out_top.sv */
// Testbench for the video output half
// Replays vectors from the data file, one probe pixel per vector,
// and checks the DUT outputs at the fixed pipeline latency
`timescale 1ns/10ps

module tb_ppu_out_top import ppu_out_pkg::*; ();

  localparam int CLK_HALF   = 20;
  localparam int RST_CYC    = 8;
  localparam int SETTLE_CYC = 8;
  localparam int PROBE_TMO  = 16;
  localparam int REC_W      = 12;
  localparam int MAX_VEC    = 64;
  localparam logic [31:0] VEC_END = 32'hFFFF_FFFF;

  // Sync nibbles {nVSYNC, nCLAMP, nHSYNC, nCSYNC}
  localparam logic [SYNC_W-1:0] SY_IDLE  = 4'hF;
  localparam logic [SYNC_W-1:0] SY_HSYNC = 4'hD;
  localparam logic [SYNC_W-1:0] SY_FRAME = 4'h5;

  logic               VCLK_Tx;
  logic               nVRST_Tx;
  logic [CFG_W-1:0]   cfg_word_i;
  logic [1:0]         vinfo_i;
  logic               use_vpll_i;
  logic               use_vga_hvsync_i;
  logic               vdata_valid_i;
  logic [VDATA_W-1:0] vdata_i;
  logic [RGB_W-1:0]   vd_o;
  logic [1:0]         ncsync_o;
  logic               nvsync_f2_o;
  logic               nhsync_f1_o;
  logic [LM_W-1:0]    vclk_tx_select_o;
  logic [7:0]         ppu_state_o;

  // Vector records, REC_W words each
  logic [31:0] vec_mem [REC_W*MAX_VEC];
  int          err_cnt;
  int          vec_cnt;

  ppu_out_top u_ppu_out_top (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .cfg_word_i       (cfg_word_i),
    .vinfo_i          (vinfo_i),
    .use_vpll_i       (use_vpll_i),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vdata_valid_i    (vdata_valid_i),
    .vdata_i          (vdata_i),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_f2_o      (nvsync_f2_o),
    .nhsync_f1_o      (nhsync_f1_o),
    .vclk_tx_select_o (vclk_tx_select_o),
    .ppu_state_o      (ppu_state_o)
  );

  // 40 ns output clock
  initial begin
    VCLK_Tx = 1'b0;
    forever #(CLK_HALF) VCLK_Tx = ~VCLK_Tx;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  // One pixel word on the next rising edge
  task automatic drive_word(input logic [SYNC_W-1:0] sy, input logic [RGB_W-1:0] rgb);
    @(posedge VCLK_Tx);
    vdata_valid_i <= 1'b1;
    vdata_i       <= {sy, rgb};
  endtask

  task automatic run_idle(input int n);
    for (int i = 0; i < n; i++)
      drive_word(SY_IDLE, '0);
  endtask

  // Pins nibble is {palmode, n64_480i, use_vpll, use_vga_hvsync}
  task automatic apply_config(input logic [CFG_W-1:0] cfg, input logic [3:0] pins);
    @(posedge VCLK_Tx);
    cfg_word_i       <= cfg;
    vinfo_i          <= pins[3:2];
    use_vpll_i       <= pins[1];
    use_vga_hvsync_i <= pins[0];
    // Resync plus decode, with margin
    run_idle(SETTLE_CYC);
  endtask

  // Frame start, whole lines, then pixels up to the probe column
  task automatic frame_lead_in(input int lines, input int pix);
    drive_word(SY_FRAME, '0);
    for (int i = 0; i < lines; i++) begin
      drive_word(SY_IDLE, '0);
      drive_word(SY_HSYNC, '0);
    end
    for (int i = 0; i < pix; i++)
      drive_word(SY_IDLE, '0);
  endtask

  task automatic run_vector(input int idx);
    int          base;
    int          lat_vd;
    int          lat_sync;
    int          cyc;
    int          err_start;
    logic [31:0] probe;
    bit          seen_vd;
    bit          seen_sync;
    base      = idx*REC_W;
    err_start = err_cnt;
    probe     = vec_mem[base+4];
    lat_vd    = vec_mem[base+5];
    lat_sync  = vec_mem[base+6];
    seen_vd   = 1'b0;
    seen_sync = 1'b0;
    cyc       = 0;
    apply_config(vec_mem[base][CFG_W-1:0], vec_mem[base+1][3:0]);
    frame_lead_in(vec_mem[base+2], vec_mem[base+3]);
    drive_word(probe[SYNC_LSB +: SYNC_W], probe[RGB_W-1:0]);

    // Idle words follow the probe, sample away from the active edge
    while (!(seen_vd && seen_sync) && cyc < PROBE_TMO) begin
      drive_word(SY_IDLE, '0);
      cyc++;
      @(negedge VCLK_Tx);
      if (cyc == lat_sync) begin
        check_val("ncsync_o", ncsync_o, vec_mem[base+8]);
        check_val("nvsync_f2_o/nhsync_f1_o", {nvsync_f2_o, nhsync_f1_o}, vec_mem[base+9]);
        check_val("vclk_tx_select_o", vclk_tx_select_o, vec_mem[base+10]);
        check_val("ppu_state_o", ppu_state_o, vec_mem[base+11]);
        seen_sync = 1'b1;
      end
      if (cyc == lat_vd) begin
        check_val("vd_o", vd_o, vec_mem[base+7]);
        seen_vd = 1'b1;
      end
    end
    if (!(seen_vd && seen_sync)) begin
      $display("Vector %0d timed out, probe pixel not seen on the outputs in %0d cycles",
               idx, PROBE_TMO);
      err_cnt++;
    end
    $display("Vector %0d finished with %0d error(s)", idx, err_cnt - err_start);
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    err_cnt          = 0;
    vec_cnt          = 0;
    nVRST_Tx         = 1'b0;
    cfg_word_i       = '0;
    vinfo_i          = '0;
    use_vpll_i       = 1'b0;
    use_vga_hvsync_i = 1'b0;
    vdata_valid_i    = 1'b0;
    vdata_i          = '0;
    $readmemh("sim/ppu_out_input.txt", vec_mem);

    for (int i = 0; i < RST_CYC; i++)
      @(posedge VCLK_Tx);
    // Everything cleared, filter select reads auto
    @(negedge VCLK_Tx);
    check_val("vd_o", vd_o, '0);
    check_val("ncsync_o", ncsync_o, '0);
    check_val("nvsync_f2_o/nhsync_f1_o", {nvsync_f2_o, nhsync_f1_o}, '0);
    check_val("vclk_tx_select_o", vclk_tx_select_o, '0);
    check_val("ppu_state_o", ppu_state_o, 32'h01);
    $display("Reset values checked, %0d error(s)", err_cnt);

    @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;
    run_idle(SETTLE_CYC);

    while (vec_cnt < MAX_VEC && vec_mem[vec_cnt*REC_W] !== VEC_END &&
           !$isunknown(vec_mem[vec_cnt*REC_W])) begin
      run_vector(vec_cnt);
      vec_cnt++;
    end
    if (vec_cnt == 0) begin
      $display("No vectors were read from sim/ppu_out_input.txt");
      err_cnt++;
    end

    $display("%0d vectors run, %0d error(s) in total", vec_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* src/ppu_out_top.sv */
// Output half of the video post-processor
// Config block beside a pattern / converter / output-stage video path
`timescale 1ns/10ps

module ppu_out_top import ppu_out_pkg::*; (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  logic [CFG_W-1:0]   cfg_word_i,
  input  logic [1:0]         vinfo_i,
  input  logic               use_vpll_i,
  input  logic               use_vga_hvsync_i,
  input  logic               vdata_valid_i,
  input  logic [VDATA_W-1:0] vdata_i,
  output logic [RGB_W-1:0]   vd_o,
  output logic [1:0]         ncsync_o,
  output logic               nvsync_f2_o,
  output logic               nhsync_f1_o,
  output logic [LM_W-1:0]    vclk_tx_select_o,
  output logic [7:0]         ppu_state_o
);

  // Decoded configuration
  logic                cfg_testpat;
  logic                cfg_xrb;
  logic                cfg_ypbpr_en;
  logic                cfg_rgsb_en;
  logic [LM_W-1:0]     cfg_linemult;
  logic                cfg_deblur;
  logic [FILTER_W-1:0] cfg_filter_sel;

  // Video path
  logic                tp_valid;
  logic [VDATA_W-1:0]  tp_data;
  logic                vsel_valid;
  logic [VDATA_W-1:0]  vsel_data;
  logic [VDATA_W-1:0]  vc_data;

  ppu_cfg_regs u_ppu_cfg_regs (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .cfg_word_i       (cfg_word_i),
    .vinfo_i          (vinfo_i),
    .use_vpll_i       (use_vpll_i),
    .cfg_testpat_o    (cfg_testpat),
    .cfg_xrb_o        (cfg_xrb),
    .cfg_ypbpr_en_o   (cfg_ypbpr_en),
    .cfg_rgsb_en_o    (cfg_rgsb_en),
    .cfg_linemult_o   (cfg_linemult),
    .cfg_deblur_o     (cfg_deblur),
    .cfg_filter_sel_o (cfg_filter_sel),
    .vclk_tx_select_o (vclk_tx_select_o),
    .ppu_state_o      (ppu_state_o)
  );

  ppu_testpattern u_ppu_testpattern (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vdata_valid_i (vdata_valid_i),
    .vdata_i       (vdata_i),
    .tp_valid_o    (tp_valid),
    .tp_data_o     (tp_data)
  );

  // Pattern replaces the multiplied stream
  assign vsel_valid = cfg_testpat ? tp_valid : vdata_valid_i;
  assign vsel_data  = cfg_testpat ? tp_data : vdata_i;

  // Output stage runs every clock, so the strobe ends at the converter
  ppu_vconv u_ppu_vconv (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .ypbpr_en_i    (cfg_ypbpr_en),
    .vdata_valid_i (vsel_valid),
    .vdata_i       (vsel_data),
    .vdata_valid_o (),
    .vdata_o       (vc_data)
  );

  ppu_out_stage u_ppu_out_stage (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .xrb_i            (cfg_xrb),
    .rgsb_en_i        (cfg_rgsb_en),
    .ypbpr_en_i       (cfg_ypbpr_en),
    .linemult_i       (cfg_linemult),
    .deblur_i         (cfg_deblur),
    .filter_sel_i     (cfg_filter_sel),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .vdata_i          (vc_data),
    .vd_o             (vd_o),
    .ncsync_o         (ncsync_o),
    .nvsync_f2_o      (nvsync_f2_o),
    .nhsync_f1_o      (nhsync_f1_o)
  );

endmodule

/* src/ppu_out_stage.sv */
// Final output registers toward the DAC
// Red/blue exchange, optional de-blur delay, composite sync pair and
// the pins shared by VGA sync and the filter add-on
`timescale 1ns/10ps

module ppu_out_stage import ppu_out_pkg::*; (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  input  logic                xrb_i,
  input  logic                rgsb_en_i,
  input  logic                ypbpr_en_i,
  input  logic [LM_W-1:0]     linemult_i,
  input  logic                deblur_i,
  input  logic [FILTER_W-1:0] filter_sel_i,
  input  logic                use_vga_hvsync_i,
  input  logic [VDATA_W-1:0]  vdata_i,
  output logic [RGB_W-1:0]    vd_o,
  output logic [1:0]          ncsync_o,
  output logic                nvsync_f2_o,
  output logic                nhsync_f1_o
);

  logic [SYNC_W-1:0] sync_in;
  logic [RGB_W-1:0]  rgb_x;
  logic [RGB_W-1:0]  deblur_q [2];
  logic [LM_W-1:0]   filter_d;
  logic [LM_W-1:0]   filter_q;

  assign sync_in = vdata_i[SYNC_LSB +: SYNC_W];

  // Swap outer channels for boards wired B/G/R
  assign rgb_x = xrb_i ? {vdata_i[B_LSB +: COLOR_W], vdata_i[G_LSB +: COLOR_W],
                          vdata_i[R_LSB +: COLOR_W]}
                       : vdata_i[RGB_W-1:0];

  // Filter code
  //   auto     follows the line multiplier
  //   1..4     SD, ED, HD, FHD as code 0..3
  assign filter_d = (filter_sel_i == '0) ? linemult_i : filter_sel_i[LM_W-1:0] - 1'b1;

  // ------------------------------------------------------------------
  // Colour and composite sync
  // ------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o        <= '0;
      ncsync_o    <= '0;
      deblur_q[0] <= '0;
      deblur_q[1] <= '0;
    end else begin
      deblur_q[0] <= rgb_x;
      deblur_q[1] <= deblur_q[0];

      // x1 takes the deeper tap, x2 and x3 the shallow one
      if (deblur_i)
        vd_o <= deblur_q[!(^linemult_i)];
      else
        vd_o <= rgb_x;

      ncsync_o[1] <= sync_in[SY_NCSYNC];
      // Sync on green or on Y only when one of them is in use
      ncsync_o[0] <= (rgsb_en_i || ypbpr_en_i) ? sync_in[SY_NCSYNC] : 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // Shared VGA sync / filter pins
  // ------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      filter_q    <= '0;
      nvsync_f2_o <= 1'b0;
      nhsync_f1_o <= 1'b0;
    end else begin
      filter_q <= filter_d;
      if (use_vga_hvsync_i) begin
        nvsync_f2_o <= sync_in[SY_NVSYNC];
        nhsync_f1_o <= sync_in[SY_NHSYNC];
      end else begin
        nvsync_f2_o <= filter_q[1];
        nhsync_f1_o <= filter_q[0];
      end
    end
  end

  a_csync_gated : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !(rgsb_en_i || ypbpr_en_i) |=> (ncsync_o[0] == 1'b0)
  );

endmodule

/* src/ppu_vconv.sv */
// RGB to YPbPr colour converter
// Three pipeline stages, input, products, sum and saturate
// Bypass takes the same stages so latency does not depend on the mode
`timescale 1ns/10ps

module ppu_vconv import ppu_out_pkg::*; (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  logic               ypbpr_en_i,
  input  logic               vdata_valid_i,
  input  logic [VDATA_W-1:0] vdata_i,
  output logic               vdata_valid_o,
  output logic [VDATA_W-1:0] vdata_o
);

  // Rows Y, Pb, Pr and columns R, G, B
  logic signed [COEF_W-1:0] coef [9];

  // Stage 1 and 2 payload, colour index 0 R, 1 G, 2 B
  logic                     s1_valid;
  logic [SYNC_W-1:0]        s1_sync;
  logic [COLOR_W-1:0]       s1_col [3];
  logic                     s2_valid;
  logic [SYNC_W-1:0]        s2_sync;
  logic [COLOR_W-1:0]       s2_col [3];
  logic signed [PROD_W-1:0] prod_q [9];

  logic signed [SUM_W-1:0]  sum_y;
  logic signed [SUM_W-1:0]  sum_pb;
  logic signed [SUM_W-1:0]  sum_pr;

  assign coef = '{COEF_Y_R,  COEF_Y_G,  COEF_Y_B,
                  COEF_PB_R, COEF_PB_G, COEF_PB_B,
                  COEF_PR_R, COEF_PR_G, COEF_PR_B};

  // Drop the 1/256 scale, add the offset, clip to 0..255
  function automatic logic [COLOR_W-1:0] sat_color(input logic signed [SUM_W-1:0] s,
                                                   input logic signed [SUM_W-1:0] ofs);
    logic signed [SUM_W-1:0] v;
    v = (s >>> COLOR_W) + ofs;
    if (v < 0)
      return '0;
    else if (v > 255)
      return '1;
    else
      return v[COLOR_W-1:0];
  endfunction

  assign sum_y  = prod_q[0] + prod_q[1] + prod_q[2];
  assign sum_pb = prod_q[3] + prod_q[4] + prod_q[5];
  assign sum_pr = prod_q[6] + prod_q[7] + prod_q[8];

  // ------------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      s1_valid      <= 1'b0;
      s1_sync       <= '0;
      s2_valid      <= 1'b0;
      s2_sync       <= '0;
      vdata_valid_o <= 1'b0;
      vdata_o       <= '0;
      for (int i = 0; i < 3; i++) begin
        s1_col[i] <= '0;
        s2_col[i] <= '0;
      end
      for (int i = 0; i < 9; i++)
        prod_q[i] <= '0;
    end else begin
      // Stage 1, register the input word
      s1_valid  <= vdata_valid_i;
      s1_sync   <= vdata_i[SYNC_LSB +: SYNC_W];
      s1_col[0] <= vdata_i[R_LSB +: COLOR_W];
      s1_col[1] <= vdata_i[G_LSB +: COLOR_W];
      s1_col[2] <= vdata_i[B_LSB +: COLOR_W];

      // Stage 2, nine products, raw RGB carried for bypass
      s2_valid <= s1_valid;
      s2_sync  <= s1_sync;
      for (int i = 0; i < 3; i++)
        s2_col[i] <= s1_col[i];
      for (int i = 0; i < 9; i++)
        prod_q[i] <= $signed({1'b0, s1_col[i%3]}) * coef[i];

      // Stage 3, Pr Y Pb sit where R G B were
      vdata_valid_o <= s2_valid;
      if (ypbpr_en_i)
        vdata_o <= {s2_sync, sat_color(sum_pr, CHROMA_OFS), sat_color(sum_y, '0),
                    sat_color(sum_pb, CHROMA_OFS)};
      else
        vdata_o <= {s2_sync, s2_col[0], s2_col[1], s2_col[2]};
    end
  end

  a_valid_latency : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    vdata_valid_o == $past(vdata_valid_i, 3)
  );

endmodule

/* src/ppu_testpattern.sv */
// Test pattern generator
// Draws an 8x8 black and white checkerboard timed by the sync bits
// of the incoming stream, sync itself is passed through
`timescale 1ns/10ps

module ppu_testpattern import ppu_out_pkg::*; (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  logic               vdata_valid_i,
  input  logic [VDATA_W-1:0] vdata_i,
  output logic               tp_valid_o,
  output logic [VDATA_W-1:0] tp_data_o
);

  logic [SYNC_W-1:0]    sync_in;
  logic [TP_PIX_W-1:0]  pix_cnt;
  logic [TP_LINE_W-1:0] line_cnt;
  logic                 nhsync_prev;
  logic                 hsync_fall;
  logic                 cell_on;

  assign sync_in    = vdata_i[SYNC_LSB +: SYNC_W];
  assign hsync_fall = nhsync_prev && !sync_in[SY_NHSYNC];

  // White where the cell bits of column and row differ
  assign cell_on = pix_cnt[TP_CELL_LOG2] ^ line_cnt[TP_CELL_LOG2];

  // ------------------------------------------------------------------
  // Position counters, advanced on valid words only
  // ------------------------------------------------------------------
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_cnt     <= '0;
      line_cnt    <= '0;
      nhsync_prev <= 1'b0;
    end else if (vdata_valid_i) begin
      nhsync_prev <= sync_in[SY_NHSYNC];

      // Column restarts inside every hsync pulse
      if (!sync_in[SY_NHSYNC])
        pix_cnt <= '0;
      else
        pix_cnt <= pix_cnt + 1'b1;

      // Row restarts in vsync, steps on each hsync leading edge
      if (!sync_in[SY_NVSYNC])
        line_cnt <= '0;
      else if (hsync_fall)
        line_cnt <= line_cnt + 1'b1;
    end
  end

  // Output register, one cycle behind the input
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      tp_valid_o <= 1'b0;
      tp_data_o  <= '0;
    end else begin
      tp_valid_o <= vdata_valid_i;
      tp_data_o  <= {sync_in, {RGB_W{cell_on}}};
    end
  end

endmodule

/* src/ppu_cfg_regs.sv */
// Configuration block of the output domain
// Brings the host word over into VCLK_Tx and decodes the per-mode
// steering levels for pattern, colour space, line multiplier and filter
`timescale 1ns/10ps

module ppu_cfg_regs import ppu_out_pkg::*; (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  input  logic [CFG_W-1:0]    cfg_word_i,
  input  logic [1:0]          vinfo_i,
  input  logic                use_vpll_i,
  output logic                cfg_testpat_o,
  output logic                cfg_xrb_o,
  output logic                cfg_ypbpr_en_o,
  output logic                cfg_rgsb_en_o,
  output logic [LM_W-1:0]     cfg_linemult_o,
  output logic                cfg_deblur_o,
  output logic [FILTER_W-1:0] cfg_filter_sel_o,
  output logic [LM_W-1:0]     vclk_tx_select_o,
  output logic [7:0]          ppu_state_o
);

  // Two-stage resync of the host word
  logic [CFG_W-1:0] cfg_meta;
  logic [CFG_W-1:0] cfg_sync;

  ppu_mode_cfg_u   mode;
  logic            palmode;
  logic            n64_480i;
  logic [LM_W-1:0] linemult_d;
  logic            filter_auto;

  assign palmode  = vinfo_i[1];
  assign n64_480i = vinfo_i[0];

  // Same byte, two meanings depending on 240p or 480i
  assign mode = cfg_sync[CFG_MODE_LSB +: MODE_W];

  // ------------------------------------------------------------------
  // Line multiplier selection
  // ------------------------------------------------------------------
  always_comb begin
    if (cfg_sync[CFG_TESTPAT_BIT]) begin
      // Pattern always runs at x1
      linemult_d = '0;
    end else if (n64_480i) begin
      linemult_d = {1'b0, mode.v480i.linex2};
    end else if (palmode || !use_vpll_i) begin
      // No x3 clock here, fold the code down to x1 or x2
      linemult_d = {1'b0, ^mode.v240p.linemult};
    end else begin
      linemult_d = mode.v240p.linemult;
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_meta <= '0;
      cfg_sync <= '0;
    end else begin
      cfg_meta <= cfg_word_i;
      cfg_sync <= cfg_meta;
    end
  end

  // Decode stage, third edge after a host change
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_testpat_o    <= 1'b0;
      cfg_xrb_o        <= 1'b0;
      cfg_ypbpr_en_o   <= 1'b0;
      cfg_rgsb_en_o    <= 1'b0;
      cfg_linemult_o   <= '0;
      cfg_deblur_o     <= 1'b0;
      cfg_filter_sel_o <= '0;
    end else begin
      cfg_testpat_o    <= cfg_sync[CFG_TESTPAT_BIT];
      cfg_xrb_o        <= cfg_sync[CFG_XRB_BIT];
      cfg_ypbpr_en_o   <= cfg_sync[CFG_YPBPR_BIT];
      cfg_rgsb_en_o    <= cfg_sync[CFG_RGSB_BIT];
      cfg_linemult_o   <= linemult_d;
      // De-blur only makes sense on 240p video, never on the pattern
      cfg_deblur_o     <= !n64_480i && mode.v240p.deblur && !cfg_sync[CFG_TESTPAT_BIT];
      cfg_filter_sel_o <= cfg_sync[CFG_FILTER_LSB +: FILTER_W];
    end
  end

  // Output pixel clock follows the multiplier
  assign vclk_tx_select_o = cfg_linemult_o;

  assign filter_auto = (cfg_filter_sel_o == '0);

  // Status back to the host
  assign ppu_state_o = {palmode, n64_480i, cfg_linemult_o, cfg_ypbpr_en_o,
                        cfg_rgsb_en_o, cfg_deblur_o, filter_auto};

  // PAL video never gets the x3 clock on the next decode
  a_no_x3_in_pal : assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    palmode |=> (cfg_linemult_o != 2'd2)
  );

endmodule

/* src/ppu_out_pkg.sv */
// Shared definitions for the video output path
// Pixel word layout, config word bit map, colour matrix and mode-byte views
package ppu_out_pkg;

  // ------------------------------------------------------------------
  // Pixel word, sync on top then R, G, B
  // ------------------------------------------------------------------
  localparam int SYNC_W  = 4;
  localparam int COLOR_W = 8;
  localparam int RGB_W   = 3*COLOR_W;
  localparam int VDATA_W = SYNC_W + RGB_W;

  // Sync bits, all active low
  // Bit 2 is nCLAMP and only rides along with the others
  localparam int SY_NVSYNC = 3;
  localparam int SY_NHSYNC = 1;
  localparam int SY_NCSYNC = 0;

  localparam int SYNC_LSB = RGB_W;
  localparam int R_LSB    = 2*COLOR_W;
  localparam int G_LSB    = COLOR_W;
  localparam int B_LSB    = 0;

  // ------------------------------------------------------------------
  // Host configuration word
  // ------------------------------------------------------------------
  localparam int CFG_W           = 16;
  localparam int CFG_TESTPAT_BIT = 0;
  localparam int CFG_XRB_BIT     = 1;
  localparam int CFG_YPBPR_BIT   = 2;
  localparam int CFG_RGSB_BIT    = 3;
  // Filter field, 0 auto, 1..4 SD, ED, HD, FHD
  localparam int CFG_FILTER_LSB  = 4;
  localparam int FILTER_W        = 3;
  localparam int CFG_MODE_LSB    = 8;
  localparam int MODE_W          = 8;
  // Line multiplier code, 0 x1, 1 x2, 2 x3
  localparam int LM_W            = 2;

  // ------------------------------------------------------------------
  // Colour matrix in 1/256 units
  // ------------------------------------------------------------------
  localparam int COEF_W = 10;
  localparam int PROD_W = COLOR_W + 1 + COEF_W;
  localparam int SUM_W  = PROD_W + 2;

  localparam logic signed [COEF_W-1:0] COEF_Y_R  =  10'sd77;
  localparam logic signed [COEF_W-1:0] COEF_Y_G  =  10'sd150;
  localparam logic signed [COEF_W-1:0] COEF_Y_B  =  10'sd29;
  localparam logic signed [COEF_W-1:0] COEF_PB_R = -10'sd43;
  localparam logic signed [COEF_W-1:0] COEF_PB_G = -10'sd85;
  localparam logic signed [COEF_W-1:0] COEF_PB_B =  10'sd128;
  localparam logic signed [COEF_W-1:0] COEF_PR_R =  10'sd128;
  localparam logic signed [COEF_W-1:0] COEF_PR_G = -10'sd107;
  localparam logic signed [COEF_W-1:0] COEF_PR_B = -10'sd21;
  // Mid-scale offset added to both chroma channels after the shift
  localparam logic signed [SUM_W-1:0]  CHROMA_OFS = 128;

  // Checkerboard cells of 8 pixels by 8 lines
  localparam int TP_CELL_LOG2 = 3;
  localparam int TP_PIX_W     = 12;
  localparam int TP_LINE_W    = 11;

  // Mode byte, read in the view of the mode currently shown
  typedef union packed {
    struct packed {
      logic [4:0] pad;
      logic       deblur;
      logic [1:0] linemult;
    } v240p;
    struct packed {
      logic [6:0] pad;
      logic       linex2;
    } v480i;
  } ppu_mode_cfg_u;

endpackage
